//--- mem_link.f
me_msg_pkg.sv
wh_noc_pkg.sv
wh_packet_encode_mem_msg.sv
wh_flit_serializer.sv
wh_flit_deserializer.sv
me_cce_to_mem_link_master.sv
me_mem_link_client.sv
me_mem_link_top.sv
tb_mem_link.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory link testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_link \
   -f mem_link.f -o tb_mem_link
if [ $? -ne 0 ]; then
   echo "Compile step failed."
   exit 1
fi

./obj_dir/tb_mem_link > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status."
   exit 1
fi

if grep -q "Result: PASSED" "$LOG"; then
   exit 0
fi
exit 1

//--- tb_mem_link.sv
/*
 * Testbench for the memory link subsystem: command stimulus, reference memory model,
 * typed response checks, random yumi back-pressure and a watchdog.
 */
`timescale 1ns/1ps

module tb_mem_link;
   import me_msg_pkg::*;
   import wh_noc_pkg::*;

   localparam wh_cord_t client_cord_c  = 4'd5;
   localparam int       reset_cycles_c = 10;
   localparam int       num_cmds_c     = 257; // 4 + 4 + 5 + 4 + 40 + 200.

   logic     clk_i;
   logic     reset_i;
   mem_msg_t mem_cmd_i;
   logic     mem_cmd_v_i;
   logic     mem_cmd_ready_o;
   mem_msg_t mem_resp_o;
   logic     mem_resp_v_o;
   logic     mem_resp_yumi_i;
   wh_cord_t my_cord_i;
   wh_cid_t  my_cid_i;
   wh_cord_t dst_cord_i;
   wh_cid_t  dst_cid_i;

   integer    seed      = 32'ha00a;
   integer    yumi_seed = 32'ha00a;
   logic      random_yumi;
   mem_data_t model_mem [16];
   mem_msg_t  exp_q [$];
   int        exp_cnt;
   int        resp_cnt;
   int        err_opcode;
   int        err_addr;
   int        err_data;
   int        err_other;

   me_mem_link_top #(
        .client_cord_p (client_cord_c)
      , .mem_words_p   (16)
   ) i_dut (
        .clk_i           (clk_i)
      , .reset_i         (reset_i)
      , .mem_cmd_i       (mem_cmd_i)
      , .mem_cmd_v_i     (mem_cmd_v_i)
      , .mem_cmd_ready_o (mem_cmd_ready_o)
      , .mem_resp_o      (mem_resp_o)
      , .mem_resp_v_o    (mem_resp_v_o)
      , .mem_resp_yumi_i (mem_resp_yumi_i)
      , .my_cord_i       (my_cord_i)
      , .my_cid_i        (my_cid_i)
      , .dst_cord_i      (dst_cord_i)
      , .dst_cid_i       (dst_cid_i)
   );

   always #50 clk_i = ~clk_i;

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic logic expect_resp(input mem_opcode_e op, input mem_addr_t addr,
                                        input mem_data_t data, input wh_cord_t dst,
                                        output mem_msg_t exp_msg);
      logic [3:0] idx;
      idx     = addr[5:2]; // Higher address bits alias.
      exp_msg = '0;
      if (dst != client_cord_c) begin
         return 1'b0; // Dropped by the client.
      end
      if (op == e_cmd_wr) begin
         model_mem[idx] = data;
         exp_msg        = {e_resp_wr, addr, mem_data_t'(0)};
      end else begin
         exp_msg = {e_resp_rd, addr, model_mem[idx]};
      end
      return 1'b1;
   endfunction

   task automatic check_opcode(input string name, input mem_opcode_e got, input mem_opcode_e exp);
      if (got !== exp) begin
         err_opcode++;
         $display("[ERROR] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
      end
   endtask

   task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
      if (got !== exp) begin
         err_addr++;
         $display("[ERROR] %0t %s got 0x%04h expected 0x%04h", $time, name, got, exp);
      end
   endtask

   task automatic check_data(input string name, input mem_data_t got, input mem_data_t exp);
      if (got !== exp) begin
         err_data++;
         $display("[ERROR] %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      end
   endtask

   // Called at posedge + 5 ns; returns at posedge + 5 ns after the handshake.
   task automatic send_cmd(input mem_opcode_e op, input mem_addr_t addr, input mem_data_t data,
                           input wh_cord_t dst);
      mem_msg_t exp_msg;
      logic     hit;
      mem_cmd_i   = {op, addr, data};
      dst_cord_i  = dst;
      mem_cmd_v_i = 1'b1;
      while (mem_cmd_ready_o !== 1'b1) begin
         @(posedge clk_i);
         #5;
      end
      hit = expect_resp(op, addr, data, dst, exp_msg);
      if (hit) begin
         exp_q.push_back(exp_msg);
         exp_cnt++;
      end
      @(posedge clk_i);
      #5;
      mem_cmd_v_i = 1'b0;
   endtask

   task automatic send_random(input logic allow_miss);
      mem_opcode_e op;
      mem_addr_t   addr;
      mem_data_t   data;
      wh_cord_t    dst;
      op   = mem_opcode_e'({1'b0, ($random(seed) & 1) == 1});
      addr = mem_addr_t'($random(seed));
      data = mem_data_t'($random(seed));
      dst  = (allow_miss && (($random(seed) & 7) == 0)) ? 4'd6 : client_cord_c;
      send_cmd(op, addr, data, dst);
   endtask

   //////////////////////////////
   // Response side
   //////////////////////////////

   initial begin : yumi_driver
      forever begin
         @(posedge clk_i);
         #5;
         if (random_yumi) begin
            mem_resp_yumi_i = mem_resp_v_o && (($random(yumi_seed) & 3) == 0);
         end else begin
            mem_resp_yumi_i = mem_resp_v_o;
         end
      end
   end

   initial begin : compare_resp
      mem_msg_t exp_msg;
      forever begin
         @(negedge clk_i); // Valid and yumi are both settled here.
         if (mem_resp_v_o && mem_resp_yumi_i) begin
            if (exp_q.size() == 0) begin
               err_other++;
               $display("Unexpected response at %0t with no command outstanding.", $time);
            end else begin
               exp_msg = exp_q.pop_front();
               check_opcode("mem_resp_o.opcode", mem_opcode_e'(mem_resp_o[49:48]),
                            mem_opcode_e'(exp_msg[49:48]));
               check_addr("mem_resp_o.addr", mem_resp_o[47:32], exp_msg[47:32]);
               check_data("mem_resp_o.data", mem_resp_o[31:0], exp_msg[31:0]);
            end
            resp_cnt++;
         end
      end
   end

   initial begin : watchdog
      repeat (num_cmds_c * 60 + reset_cycles_c) @(posedge clk_i);
      $display("Timeout: the run did not finish within the cycle budget.");
      $display("Result: FAILED");
      $finish;
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial begin : stimulus
      clk_i           = 1'b0;
      reset_i         = 1'b1;
      mem_cmd_i       = '0;
      mem_cmd_v_i     = 1'b0;
      mem_resp_yumi_i = 1'b0;
      my_cord_i       = 4'd1;
      my_cid_i        = 2'd0;
      dst_cord_i      = client_cord_c;
      dst_cid_i       = 2'd1;
      random_yumi     = 1'b0;
      exp_cnt         = 0;
      resp_cnt        = 0;
      err_opcode      = 0;
      err_addr        = 0;
      err_data        = 0;
      err_other       = 0;
      for (int i = 0; i < 16; i++) begin
         model_mem[i] = '0;
      end
      repeat (reset_cycles_c) @(posedge clk_i);
      #5;
      reset_i = 1'b0;
      if (mem_cmd_ready_o !== 1'b1 || mem_resp_v_o !== 1'b0) begin
         err_other++;
         $display("Handshake outputs are not idle after reset.");
      end

      // Unwritten words read as zero.
      send_cmd(e_cmd_rd, 16'h0000, '0, client_cord_c);
      send_cmd(e_cmd_rd, 16'h0004, '0, client_cord_c);
      send_cmd(e_cmd_rd, 16'h0010, '0, client_cord_c);
      send_cmd(e_cmd_rd, 16'h003c, '0, client_cord_c);

      send_cmd(e_cmd_wr, 16'h0004, 32'h1111_0001, client_cord_c);
      send_cmd(e_cmd_wr, 16'h0008, 32'h2222_0002, client_cord_c);
      send_cmd(e_cmd_wr, 16'h000c, 32'h3333_0003, client_cord_c);
      send_cmd(e_cmd_wr, 16'h003c, 32'hffff_000f, client_cord_c);

      // Last write wins, and addresses alias above bit 5.
      send_cmd(e_cmd_wr, 16'h0008, 32'h2222_0022, client_cord_c);
      send_cmd(e_cmd_rd, 16'h0048, '0, client_cord_c);
      send_cmd(e_cmd_rd, 16'h0104, '0, client_cord_c);
      send_cmd(e_cmd_rd, 16'hfffc, '0, client_cord_c);
      send_cmd(e_cmd_rd, 16'h000c, '0, client_cord_c);

      // Misaddressed commands change nothing.
      send_cmd(e_cmd_wr, 16'h0004, 32'h0bad_0bad, 4'd3);
      send_cmd(e_cmd_rd, 16'h0004, '0, client_cord_c);
      send_cmd(e_cmd_rd, 16'h0008, '0, 4'd9);
      send_cmd(e_cmd_rd, 16'h0008, '0, client_cord_c);

      @(negedge clk_i);
      random_yumi = 1'b1;
      @(posedge clk_i);
      #5;
      for (int i = 0; i < 40; i++) begin
         send_random(1'b1); // Back to back.
      end
      for (int i = 0; i < 200; i++) begin
         send_random(1'b0);
         if (($random(seed) & 7) == 0) begin
            @(posedge clk_i);
            #5;
         end
      end

      while (exp_q.size() != 0) begin
         @(posedge clk_i);
      end
      repeat (30) @(posedge clk_i); // Room for a stray response.
      if (resp_cnt != exp_cnt) begin
         err_other++;
         $display("Got %0d responses but %0d were expected.", resp_cnt, exp_cnt);
      end

      $display("Errors: opcode %0d, addr %0d, data %0d, other %0d",
               err_opcode, err_addr, err_data, err_other);
      if (err_opcode + err_addr + err_data + err_other == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- me_mem_link_top.sv
/*
 * Memory link subsystem top: master and client joined by command and response links.
 */
`timescale 1ns/1ps

module me_mem_link_top #(
     parameter wh_noc_pkg::wh_cord_t client_cord_p = 4'd5
   , parameter int                   mem_words_p   = 16
) (
     input  logic                  clk_i
   , input  logic                  reset_i

   , input  me_msg_pkg::mem_msg_t  mem_cmd_i
   , input  logic                  mem_cmd_v_i
   , output logic                  mem_cmd_ready_o

   , output me_msg_pkg::mem_msg_t  mem_resp_o
   , output logic                  mem_resp_v_o
   , input  logic                  mem_resp_yumi_i

   , input  wh_noc_pkg::wh_cord_t  my_cord_i
   , input  wh_noc_pkg::wh_cid_t   my_cid_i
   , input  wh_noc_pkg::wh_cord_t  dst_cord_i
   , input  wh_noc_pkg::wh_cid_t   dst_cid_i
);
   import wh_noc_pkg::*;

   logic     cmd_link_v;
   wh_flit_t cmd_link_flit;
   logic     cmd_link_ready;
   logic     resp_link_v;
   wh_flit_t resp_link_flit;
   logic     resp_link_ready;

   me_cce_to_mem_link_master i_master (
        .clk_i             (clk_i)
      , .reset_i           (reset_i)
      , .mem_cmd_i         (mem_cmd_i)
      , .mem_cmd_v_i       (mem_cmd_v_i)
      , .mem_cmd_ready_o   (mem_cmd_ready_o)
      , .mem_resp_o        (mem_resp_o)
      , .mem_resp_v_o      (mem_resp_v_o)
      , .mem_resp_yumi_i   (mem_resp_yumi_i)
      , .my_cord_i         (my_cord_i)
      , .my_cid_i          (my_cid_i)
      , .dst_cord_i        (dst_cord_i)
      , .dst_cid_i         (dst_cid_i)
      , .cmd_link_v_o      (cmd_link_v)
      , .cmd_link_flit_o   (cmd_link_flit)
      , .cmd_link_ready_i  (cmd_link_ready)
      , .resp_link_v_i     (resp_link_v)
      , .resp_link_flit_i  (resp_link_flit)
      , .resp_link_ready_o (resp_link_ready)
   );

   me_mem_link_client #(
        .client_cord_p (client_cord_p)
      , .mem_words_p   (mem_words_p)
   ) i_client (
        .clk_i             (clk_i)
      , .reset_i           (reset_i)
      , .cmd_link_v_i      (cmd_link_v)
      , .cmd_link_flit_i   (cmd_link_flit)
      , .cmd_link_ready_o  (cmd_link_ready)
      , .resp_link_v_o     (resp_link_v)
      , .resp_link_flit_o  (resp_link_flit)
      , .resp_link_ready_i (resp_link_ready)
   );

endmodule

//--- me_mem_link_client.sv
/*
 * Memory-side link client: coordinate filter, word store and response sender.
 */
`timescale 1ns/1ps

module me_mem_link_client #(
     parameter wh_noc_pkg::wh_cord_t client_cord_p = 4'd5
   , parameter int                   mem_words_p   = 16
) (
     input  logic                  clk_i
   , input  logic                  reset_i

   , input  logic                  cmd_link_v_i
   , input  wh_noc_pkg::wh_flit_t  cmd_link_flit_i
   , output logic                  cmd_link_ready_o

   , output logic                  resp_link_v_o
   , output wh_noc_pkg::wh_flit_t  resp_link_flit_o
   , input  logic                  resp_link_ready_i
);
   import me_msg_pkg::*;
   import wh_noc_pkg::*;

   localparam int idx_width_lp = $clog2(mem_words_p);

   wh_packet_t                req_packet;
   logic                      req_v;
   logic                      req_yumi;
   logic                      req_hit;
   mem_opcode_e               req_op;
   mem_addr_t                 req_addr;
   mem_data_t                 req_data;
   logic [idx_width_lp-1:0]   req_idx;

   mem_data_t                 mem_r [mem_words_p];
   mem_msg_t                  resp_msg_n;
   mem_msg_t                  resp_msg_r;
   wh_cord_t                  resp_dst_cord_r;
   wh_cid_t                   resp_dst_cid_r;
   wh_cid_t                   resp_src_cid_r;
   logic                      resp_v_r;
   logic                      ser_ready;
   wh_packet_t                resp_packet;

   wh_flit_deserializer i_cmd_deser (
        .clk_i        (clk_i)
      , .reset_i      (reset_i)
      , .link_v_i     (cmd_link_v_i)
      , .link_flit_i  (cmd_link_flit_i)
      , .link_ready_o (cmd_link_ready_o)
      , .packet_o     (req_packet)
      , .v_o          (req_v)
      , .yumi_i       (req_yumi)
   );

   //////////////////////////////
   // Request decode
   //////////////////////////////

   assign req_hit  = (req_packet[0 +: $bits(wh_cord_t)] == client_cord_p);
   assign req_addr = req_packet[wh_hdr_lsb_c +: $bits(mem_addr_t)];
   assign req_op   = mem_opcode_e'(req_packet[wh_hdr_lsb_c + $bits(mem_addr_t) +: 2]);
   assign req_data = req_packet[wh_data_lsb_c +: $bits(mem_data_t)];
   assign req_idx  = req_addr[2 +: idx_width_lp]; // Word address.

   // Misaddressed packets are taken too, and simply dropped.
   assign req_yumi = req_v && (!resp_v_r || ser_ready);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < mem_words_p; i++) begin
            mem_r[i] <= '0;
         end
      end else if (req_yumi && req_hit && (req_op == e_cmd_wr)) begin
         mem_r[req_idx] <= req_data;
      end
   end

   always_comb begin
      if (req_op == e_cmd_wr) begin
         resp_msg_n = {e_resp_wr, req_addr, mem_data_t'(0)};
      end else begin
         resp_msg_n = {e_resp_rd, req_addr, mem_r[req_idx]};
      end
   end

   //////////////////////////////
   // Response register
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         resp_v_r <= 1'b0;
      end else if (req_yumi && req_hit) begin
         resp_v_r <= 1'b1;
      end else if (ser_ready) begin
         resp_v_r <= 1'b0; // Handed to the serializer.
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_yumi && req_hit) begin
         resp_msg_r      <= resp_msg_n;
         resp_dst_cord_r <= req_packet[wh_src_cord_lsb_c +: $bits(wh_cord_t)];
         resp_dst_cid_r  <= req_packet[wh_src_cid_lsb_c +: $bits(wh_cid_t)];
         resp_src_cid_r  <= req_packet[wh_dst_cid_lsb_c +: $bits(wh_cid_t)];
      end
   end

   wh_packet_encode_mem_msg i_resp_encode (
        .msg_i      (resp_msg_r)
      , .src_cord_i (client_cord_p)
      , .src_cid_i  (resp_src_cid_r)
      , .dst_cord_i (resp_dst_cord_r)
      , .dst_cid_i  (resp_dst_cid_r)
      , .packet_o   (resp_packet)
   );

   wh_flit_serializer i_resp_ser (
        .clk_i        (clk_i)
      , .reset_i      (reset_i)
      , .packet_i     (resp_packet)
      , .v_i          (resp_v_r)
      , .ready_o      (ser_ready)
      , .link_v_o     (resp_link_v_o)
      , .link_flit_o  (resp_link_flit_o)
      , .link_ready_i (resp_link_ready_i)
   );

endmodule

//--- me_cce_to_mem_link_master.sv
/*
 * Engine-side memory link master: command encoder, flit sender, response unpacker.
 */
`timescale 1ns/1ps

module me_cce_to_mem_link_master (
     input  logic                  clk_i
   , input  logic                  reset_i

   , input  me_msg_pkg::mem_msg_t  mem_cmd_i
   , input  logic                  mem_cmd_v_i
   , output logic                  mem_cmd_ready_o

   , output me_msg_pkg::mem_msg_t  mem_resp_o
   , output logic                  mem_resp_v_o
   , input  logic                  mem_resp_yumi_i

   , input  wh_noc_pkg::wh_cord_t  my_cord_i
   , input  wh_noc_pkg::wh_cid_t   my_cid_i
   , input  wh_noc_pkg::wh_cord_t  dst_cord_i
   , input  wh_noc_pkg::wh_cid_t   dst_cid_i

   , output logic                  cmd_link_v_o
   , output wh_noc_pkg::wh_flit_t  cmd_link_flit_o
   , input  logic                  cmd_link_ready_i

   , input  logic                  resp_link_v_i
   , input  wh_noc_pkg::wh_flit_t  resp_link_flit_i
   , output logic                  resp_link_ready_o
);
   import me_msg_pkg::*;
   import wh_noc_pkg::*;

   wh_packet_t cmd_packet;
   wh_packet_t resp_packet;

   wh_packet_encode_mem_msg i_cmd_encode (
        .msg_i      (mem_cmd_i)
      , .src_cord_i (my_cord_i)
      , .src_cid_i  (my_cid_i)
      , .dst_cord_i (dst_cord_i)
      , .dst_cid_i  (dst_cid_i)
      , .packet_o   (cmd_packet)
   );

   wh_flit_serializer i_cmd_ser (
        .clk_i        (clk_i)
      , .reset_i      (reset_i)
      , .packet_i     (cmd_packet)
      , .v_i          (mem_cmd_v_i)
      , .ready_o      (mem_cmd_ready_o)
      , .link_v_o     (cmd_link_v_o)
      , .link_flit_o  (cmd_link_flit_o)
      , .link_ready_i (cmd_link_ready_i)
   );

   wh_flit_deserializer i_resp_deser (
        .clk_i        (clk_i)
      , .reset_i      (reset_i)
      , .link_v_i     (resp_link_v_i)
      , .link_flit_i  (resp_link_flit_i)
      , .link_ready_o (resp_link_ready_o)
      , .packet_o     (resp_packet)
      , .v_o          (mem_resp_v_o)
      , .yumi_i       (mem_resp_yumi_i)
   );

   // Header and data back into message order.
   assign mem_resp_o = {resp_packet[wh_hdr_lsb_c +: mem_hdr_width_c],
                        resp_packet[wh_data_lsb_c +: $bits(mem_data_t)]};

endmodule

//--- wh_flit_deserializer.sv
/*
 * Flit to packet deserializer with a valid/yumi output.
 */
`timescale 1ns/1ps

module wh_flit_deserializer (
     input  logic                    clk_i
   , input  logic                    reset_i

   , input  logic                    link_v_i
   , input  wh_noc_pkg::wh_flit_t    link_flit_i
   , output logic                    link_ready_o

   , output wh_noc_pkg::wh_packet_t  packet_o
   , output logic                    v_o
   , input  logic                    yumi_i
);
   import wh_noc_pkg::*;

   typedef enum logic {e_recv, e_full} state_e;

   state_e     state_r;
   wh_packet_t packet_r;
   wh_len_t    len_r;
   wh_len_t    cnt_r;
   wh_len_t    cur_len;
   logic       flit_xfer;

   assign link_ready_o = (state_r == e_recv);
   assign v_o          = (state_r == e_full);
   assign packet_o     = packet_r;
   assign flit_xfer    = link_v_i && link_ready_o;

   // Length comes from the flit itself on the first beat.
   assign cur_len = (cnt_r == '0) ? link_flit_i[wh_len_lsb_c +: $bits(wh_len_t)] : len_r;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_r <= e_recv;
         cnt_r   <= '0;
         len_r   <= '0;
      end else if (state_r == e_full) begin
         if (yumi_i) begin
            state_r <= e_recv;
         end
      end else if (flit_xfer) begin
         len_r <= cur_len;
         if (cnt_r == cur_len) begin
            state_r <= e_full;
            cnt_r   <= '0;
         end else begin
            cnt_r <= cnt_r + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (flit_xfer) begin
         if (cnt_r == '0) begin
            packet_r <= wh_packet_t'(link_flit_i); // Clears slots a short packet skips.
         end else begin
            packet_r[cnt_r * wh_flit_width_c +: wh_flit_width_c] <= link_flit_i;
         end
      end
   end

endmodule

//--- wh_flit_serializer.sv
/*
 * Packet to flit serializer on a ready-and link.
 */
`timescale 1ns/1ps

module wh_flit_serializer (
     input  logic                    clk_i
   , input  logic                    reset_i

   , input  wh_noc_pkg::wh_packet_t  packet_i
   , input  logic                    v_i
   , output logic                    ready_o

   , output logic                    link_v_o
   , output wh_noc_pkg::wh_flit_t    link_flit_o
   , input  logic                    link_ready_i
);
   import wh_noc_pkg::*;

   typedef enum logic {e_idle, e_send} state_e;

   state_e     state_r;
   wh_packet_t packet_r;
   wh_len_t    len_r;
   wh_len_t    cnt_r;
   logic       last_flit;

   assign ready_o     = (state_r == e_idle);
   assign link_v_o    = (state_r == e_send);
   assign link_flit_o = packet_r[cnt_r * wh_flit_width_c +: wh_flit_width_c];
   assign last_flit   = (cnt_r == len_r);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_r <= e_idle;
         cnt_r   <= '0;
      end else begin
         case (state_r)
            e_idle: begin
               if (v_i) begin
                  state_r <= e_send;
                  cnt_r   <= '0;
               end
            end
            e_send: begin
               if (link_ready_i) begin
                  if (last_flit) begin
                     state_r <= e_idle; // Ready again next cycle.
                  end else begin
                     cnt_r <= cnt_r + 1'b1;
                  end
               end
            end
            default: state_r <= e_idle;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (ready_o && v_i) begin
         packet_r <= packet_i;
         len_r    <= packet_i[wh_len_lsb_c +: $bits(wh_len_t)];
      end
   end

endmodule

//--- wh_packet_encode_mem_msg.sv
/*
 * Combinational packet builder for memory messages, with flit count.
 */
`timescale 1ns/1ps

module wh_packet_encode_mem_msg (
     input  me_msg_pkg::mem_msg_t    msg_i
   , input  wh_noc_pkg::wh_cord_t    src_cord_i
   , input  wh_noc_pkg::wh_cid_t     src_cid_i
   , input  wh_noc_pkg::wh_cord_t    dst_cord_i
   , input  wh_noc_pkg::wh_cid_t     dst_cid_i
   , output wh_noc_pkg::wh_packet_t  packet_o
);
   import me_msg_pkg::*;
   import wh_noc_pkg::*;

   mem_opcode_e opcode;
   logic        has_data;

   assign opcode   = mem_opcode_e'(msg_i[mem_msg_width_c-1 -: 2]);
   assign has_data = (opcode == e_cmd_wr) || (opcode == e_resp_rd);

   always_comb begin
      packet_o = '0; // Unsent flits stay defined.
      packet_o[0 +: $bits(wh_cord_t)]                 = dst_cord_i;
      packet_o[wh_len_lsb_c +: $bits(wh_len_t)]       = has_data ? wh_len_data_c
                                                                 : wh_len_nodata_c;
      packet_o[wh_dst_cid_lsb_c +: $bits(wh_cid_t)]   = dst_cid_i;
      packet_o[wh_src_cord_lsb_c +: $bits(wh_cord_t)] = src_cord_i;
      packet_o[wh_src_cid_lsb_c +: $bits(wh_cid_t)]   = src_cid_i;
      packet_o[wh_hdr_lsb_c +: mem_hdr_width_c]       = msg_i[mem_msg_width_c-1 -: mem_hdr_width_c];
      if (has_data) begin
         packet_o[wh_data_lsb_c +: $bits(mem_data_t)] = msg_i[$bits(mem_data_t)-1:0];
      end
   end

endmodule

//--- wh_noc_pkg.sv
/*
 * Wormhole network types: coordinate, cid, length, flit, packet and field offsets.
 */
package wh_noc_pkg;

   localparam int wh_flit_width_c   = 16;
   localparam int wh_packet_width_c = 80; // Five flits.

   //////////////////////////////
   // Packet field offsets
   //////////////////////////////

   // Destination coordinate sits at bit 0.
   localparam int wh_len_lsb_c      = 4;
   localparam int wh_dst_cid_lsb_c  = 7;
   localparam int wh_src_cord_lsb_c = 9;
   localparam int wh_src_cid_lsb_c  = 13;
   localparam int wh_hdr_lsb_c      = 15;
   localparam int wh_data_lsb_c     = 48; // Data fills the top two flits.

   typedef logic [3:0] wh_cord_t;
   typedef logic [1:0] wh_cid_t;
   typedef logic [2:0] wh_len_t; // Flit count minus one.
   typedef logic [wh_flit_width_c-1:0]   wh_flit_t;
   typedef logic [wh_packet_width_c-1:0] wh_packet_t;

   localparam wh_len_t wh_len_data_c   = 3'd4;
   localparam wh_len_t wh_len_nodata_c = 3'd2; // 33 header bits need three flits.

endpackage

//--- me_msg_pkg.sv
/*
 * Memory message types: opcode enum, address, data word and the packed message.
 */
package me_msg_pkg;

   localparam int mem_msg_width_c = 50;
   localparam int mem_hdr_width_c = 18; // Opcode plus address.

   //////////////////////////////
   // Message fields
   //////////////////////////////

   typedef enum logic [1:0] {
      e_cmd_rd  = 2'b00,
      e_cmd_wr  = 2'b01,
      e_resp_rd = 2'b10,
      e_resp_wr = 2'b11
   } mem_opcode_e;

   typedef logic [15:0] mem_addr_t; // Byte address.
   typedef logic [31:0] mem_data_t; // One word per block.

   // Opcode on top, then address, then data.
   typedef logic [mem_msg_width_c-1:0] mem_msg_t;

endpackage
